//--- design/draw_background.sv
module draw_background (
    input  logic                clk,
    input  logic                rst,
    input  game_pkg::game_mode_e mode,
    input  logic [11:0]         hcount_in,
    input  logic [11:0]         vcount_in,
    input  logic                hsync_in,
    input  logic                vsync_in,
    input  logic                hblnk_in,
    input  logic                vblnk_in,
    output logic [11:0]         hcount_out,
    output logic [11:0]         vcount_out,
    output logic                hsync_out,
    output logic                vsync_out,
    output logic                hblnk_out,
    output logic                vblnk_out,
    output logic [11:0]         rgb
);

    import game_pkg::*;

    logic [11:0] rgb_nxt;
    logic        title_hit;
    logic        ring_hit;

    // Title bars use lower < x <= upper
    function automatic logic in_bar(input logic [11:0] x, input logic [11:0] y,
                                    input logic [11:0] x0, input logic [11:0] x1,
                                    input logic [11:0] y0, input logic [11:0] y1);
        return (x > x0) && (x <= x1) && (y > y0) && (y <= y1);
    endfunction

    // Playfield ring uses lower <= x < upper
    function automatic logic in_rect(input logic [11:0] x, input logic [11:0] y,
                                     input logic [11:0] x0, input logic [11:0] x1,
                                     input logic [11:0] y0, input logic [11:0] y1);
        return (x >= x0) && (x < x1) && (y >= y0) && (y < y1);
    endfunction

    always_comb begin
        title_hit =
            // M
            in_bar(hcount_in, vcount_in, 12'd170, 12'd210, 12'd90, 12'd250) ||
            in_bar(hcount_in, vcount_in, 12'd170, 12'd370, 12'd50, 12'd90)  ||
            in_bar(hcount_in, vcount_in, 12'd250, 12'd290, 12'd90, 12'd250) ||
            in_bar(hcount_in, vcount_in, 12'd330, 12'd370, 12'd90, 12'd250) ||
            // E
            in_bar(hcount_in, vcount_in, 12'd420, 12'd460, 12'd50, 12'd250)  ||
            in_bar(hcount_in, vcount_in, 12'd460, 12'd500, 12'd50, 12'd90)   ||
            in_bar(hcount_in, vcount_in, 12'd460, 12'd500, 12'd130, 12'd170) ||
            in_bar(hcount_in, vcount_in, 12'd460, 12'd500, 12'd210, 12'd250) ||
            // N
            in_bar(hcount_in, vcount_in, 12'd550, 12'd590, 12'd90, 12'd250) ||
            in_bar(hcount_in, vcount_in, 12'd550, 12'd670, 12'd50, 12'd90)  ||
            in_bar(hcount_in, vcount_in, 12'd630, 12'd670, 12'd90, 12'd250) ||
            // U
            in_bar(hcount_in, vcount_in, 12'd720, 12'd760, 12'd50, 12'd210)  ||
            in_bar(hcount_in, vcount_in, 12'd720, 12'd840, 12'd210, 12'd250) ||
            in_bar(hcount_in, vcount_in, 12'd800, 12'd840, 12'd50, 12'd210);

        // Left, top, bottom and right sides of the ring
        ring_hit =
            in_rect(hcount_in, vcount_in, left_h_line - border, left_h_line,
                    top_v_line - border, bottom_v_line + border) ||
            in_rect(hcount_in, vcount_in, left_h_line, right_h_line,
                    top_v_line - border, top_v_line) ||
            in_rect(hcount_in, vcount_in, left_h_line, right_h_line,
                    bottom_v_line, bottom_v_line + border) ||
            in_rect(hcount_in, vcount_in, right_h_line, right_h_line + border,
                    top_v_line - border, bottom_v_line + border);

        case (mode)
            mode_menu, mode_game: begin
                if (hblnk_in || vblnk_in) begin
                    rgb_nxt = col_black;
                end else if (vcount_in == 12'd0) begin
                    rgb_nxt = col_yellow;
                end else if (vcount_in == v_active - 12'd1) begin
                    rgb_nxt = col_red;
                end else if (hcount_in == 12'd0) begin
                    rgb_nxt = col_green;
                end else if (hcount_in == h_active - 12'd1) begin
                    rgb_nxt = col_blue;
                end else if ((mode == mode_menu) ? title_hit : ring_hit) begin
                    rgb_nxt = col_white;
                end else begin
                    rgb_nxt = col_black;
                end
            end
            // Flat screens cover blanking too
            mode_victory: rgb_nxt = col_victory;
            mode_over:    rgb_nxt = col_over;
            mode_wait:    rgb_nxt = col_wait;
            default:      rgb_nxt = col_black;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount_out <= 12'd0;
            vcount_out <= 12'd0;
            hsync_out  <= 1'b0;
            vsync_out  <= 1'b0;
            hblnk_out  <= 1'b0;
            vblnk_out  <= 1'b0;
            rgb        <= 12'd0;
        end else begin
            hcount_out <= hcount_in;
            vcount_out <= vcount_in;
            hsync_out  <= hsync_in;
            vsync_out  <= vsync_in;
            hblnk_out  <= hblnk_in;
            vblnk_out  <= vblnk_in;
            rgb        <= rgb_nxt;
        end
    end

endmodule

//--- design/draw_marker.sv
module draw_marker (
    input  logic                clk,
    input  logic                rst,
    input  game_pkg::game_mode_e mode,
    input  logic [11:0]         player_x,
    input  logic [11:0]         player_y,
    input  logic [11:0]         hcount_in,
    input  logic [11:0]         vcount_in,
    input  logic                hsync_in,
    input  logic                vsync_in,
    input  logic                hblnk_in,
    input  logic                vblnk_in,
    input  logic [11:0]         rgb_in,
    output logic [11:0]         vga_hcount,
    output logic [11:0]         vga_vcount,
    output logic                vga_hsync,
    output logic                vga_vsync,
    output logic                vga_blnk,
    output logic [11:0]         vga_rgb
);

    import game_pkg::*;

    // Mode delayed to match the pixel coming out of the painter
    game_mode_e  mode_q;
    logic [11:0] pos_x;
    logic [11:0] pos_y;
    logic        on_marker;

    always_comb begin
        // Keep the square inside the playfield interior
        if (player_x < left_h_line) begin
            pos_x = left_h_line;
        end else if (player_x > right_h_line - marker_size) begin
            pos_x = right_h_line - marker_size;
        end else begin
            pos_x = player_x;
        end
        if (player_y < top_v_line) begin
            pos_y = top_v_line;
        end else if (player_y > bottom_v_line - marker_size) begin
            pos_y = bottom_v_line - marker_size;
        end else begin
            pos_y = player_y;
        end

        on_marker = (mode_q == mode_game) && !hblnk_in && !vblnk_in &&
                    (hcount_in >= pos_x) && (hcount_in < pos_x + marker_size) &&
                    (vcount_in >= pos_y) && (vcount_in < pos_y + marker_size);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mode_q     <= mode_menu;
            vga_hcount <= 12'd0;
            vga_vcount <= 12'd0;
            vga_hsync  <= 1'b0;
            vga_vsync  <= 1'b0;
            vga_blnk   <= 1'b0;
            vga_rgb    <= 12'd0;
        end else begin
            mode_q     <= mode;
            vga_hcount <= hcount_in;
            vga_vcount <= vcount_in;
            vga_hsync  <= hsync_in;
            vga_vsync  <= vsync_in;
            vga_blnk   <= hblnk_in | vblnk_in;
            vga_rgb    <= on_marker ? col_marker : rgb_in;
        end
    end

endmodule

//--- design/game_display_top.sv
module game_display_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 btn_left,
    input  logic                 click,
    input  logic                 play_hit,
    input  logic                 win,
    input  logic                 lose,
    input  logic                 multi,
    input  logic                 peer_ready,
    input  logic [11:0]          player_x,
    input  logic [11:0]          player_y,
    output logic [11:0]          vga_hcount,
    output logic [11:0]          vga_vcount,
    output logic                 vga_hsync,
    output logic                 vga_vsync,
    output logic                 vga_blnk,
    output logic [11:0]          vga_rgb,
    output game_pkg::game_mode_e mode
);

    // Raw raster from the timing generator
    logic [11:0] hcount;
    logic [11:0] vcount;
    logic        hsync;
    logic        vsync;
    logic        hblnk;
    logic        vblnk;

    // Raster and colour after the background stage
    logic [11:0] bg_hcount;
    logic [11:0] bg_vcount;
    logic        bg_hsync;
    logic        bg_vsync;
    logic        bg_hblnk;
    logic        bg_vblnk;
    logic [11:0] bg_rgb;

    vga_timing u_vga_timing (
        .clk    (clk),
        .rst    (rst),
        .hcount (hcount),
        .vcount (vcount),
        .hsync  (hsync),
        .vsync  (vsync),
        .hblnk  (hblnk),
        .vblnk  (vblnk)
    );

    game_mode_ctrl u_game_mode_ctrl (
        .clk        (clk),
        .rst        (rst),
        .btn_left   (btn_left),
        .click      (click),
        .play_hit   (play_hit),
        .win        (win),
        .lose       (lose),
        .multi      (multi),
        .peer_ready (peer_ready),
        .mode       (mode)
    );

    draw_background u_draw_background (
        .clk        (clk),
        .rst        (rst),
        .mode       (mode),
        .hcount_in  (hcount),
        .vcount_in  (vcount),
        .hsync_in   (hsync),
        .vsync_in   (vsync),
        .hblnk_in   (hblnk),
        .vblnk_in   (vblnk),
        .hcount_out (bg_hcount),
        .vcount_out (bg_vcount),
        .hsync_out  (bg_hsync),
        .vsync_out  (bg_vsync),
        .hblnk_out  (bg_hblnk),
        .vblnk_out  (bg_vblnk),
        .rgb        (bg_rgb)
    );

    draw_marker u_draw_marker (
        .clk        (clk),
        .rst        (rst),
        .mode       (mode),
        .player_x   (player_x),
        .player_y   (player_y),
        .hcount_in  (bg_hcount),
        .vcount_in  (bg_vcount),
        .hsync_in   (bg_hsync),
        .vsync_in   (bg_vsync),
        .hblnk_in   (bg_hblnk),
        .vblnk_in   (bg_vblnk),
        .rgb_in     (bg_rgb),
        .vga_hcount (vga_hcount),
        .vga_vcount (vga_vcount),
        .vga_hsync  (vga_hsync),
        .vga_vsync  (vga_vsync),
        .vga_blnk   (vga_blnk),
        .vga_rgb    (vga_rgb)
    );

endmodule

//--- design/game_mode_ctrl.sv
module game_mode_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                btn_left,
    input  logic                click,
    input  logic                play_hit,
    input  logic                win,
    input  logic                lose,
    input  logic                multi,
    input  logic                peer_ready,
    output game_pkg::game_mode_e mode
);

    import game_pkg::*;

    game_mode_e mode_nxt;

    always_comb begin
        mode_nxt = mode;
        // Board button leaves any screen other than the menu
        if (btn_left && (mode != mode_menu)) begin
            mode_nxt = mode_menu;
        end else begin
            case (mode)
                mode_menu: begin
                    if (play_hit) begin
                        mode_nxt = multi ? mode_wait : mode_game;
                    end
                end
                mode_wait: begin
                    if (peer_ready) begin
                        mode_nxt = mode_game;
                    end
                end
                mode_game: begin
                    // A win beats a loss in the same cycle
                    if (win) begin
                        mode_nxt = mode_victory;
                    end else if (lose) begin
                        mode_nxt = mode_over;
                    end
                end
                mode_victory: begin
                    if (click) begin
                        mode_nxt = mode_menu;
                    end
                end
                mode_over: begin
                    // Click anywhere goes back to menu, PLAY restarts
                    if (click) begin
                        mode_nxt = mode_menu;
                    end else if (play_hit) begin
                        mode_nxt = mode_game;
                    end
                end
                default: begin
                    mode_nxt = mode_menu;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mode <= mode_menu;
        end else begin
            mode <= mode_nxt;
        end
    end

endmodule

//--- design/game_pkg.sv
package game_pkg;

    // Horizontal raster geometry for 1024x768 at a 65 MHz pixel rate
    localparam logic [11:0] h_active     = 12'd1024;
    localparam logic [11:0] h_total      = 12'd1344;
    localparam logic [11:0] h_sync_start = 12'd1048;
    localparam logic [11:0] h_sync_end   = 12'd1184;

    // Vertical raster geometry in lines
    localparam logic [11:0] v_active     = 12'd768;
    localparam logic [11:0] v_total      = 12'd806;
    localparam logic [11:0] v_sync_start = 12'd771;
    localparam logic [11:0] v_sync_end   = 12'd777;

    // Playfield inner bounds and ring thickness
    localparam logic [11:0] top_v_line    = 12'd317;
    localparam logic [11:0] bottom_v_line = 12'd617;
    localparam logic [11:0] left_h_line   = 12'd361;
    localparam logic [11:0] right_h_line  = 12'd661;
    localparam logic [11:0] border        = 12'd10;

    localparam logic [11:0] marker_size = 12'd16;

    // Colours as 4-bit R, G, B
    localparam logic [11:0] col_black   = 12'h000;
    localparam logic [11:0] col_white   = 12'hfff;
    localparam logic [11:0] col_yellow  = 12'hff0;
    localparam logic [11:0] col_red     = 12'hf00;
    localparam logic [11:0] col_green   = 12'h0f0;
    localparam logic [11:0] col_blue    = 12'h00f;
    localparam logic [11:0] col_victory = 12'h2f2;
    localparam logic [11:0] col_over    = 12'hf22;
    localparam logic [11:0] col_wait    = 12'h22f;
    localparam logic [11:0] col_marker  = 12'hfa0;

    typedef enum logic [2:0] {
        mode_menu    = 3'd0,
        mode_game    = 3'd1,
        mode_victory = 3'd2,
        mode_over    = 3'd3,
        mode_wait    = 3'd4
    } game_mode_e;

endpackage

//--- design/vga_timing.sv
module vga_timing (
    input  logic        clk,
    input  logic        rst,
    output logic [11:0] hcount,
    output logic [11:0] vcount,
    output logic        hsync,
    output logic        vsync,
    output logic        hblnk,
    output logic        vblnk
);

    import game_pkg::*;

    logic [11:0] hcount_nxt;
    logic [11:0] vcount_nxt;
    logic        h_wrap;

    // Flags come from the next counter values so they line up with the counters
    always_comb begin
        h_wrap = (hcount == h_total - 12'd1);
        if (h_wrap) begin
            hcount_nxt = 12'd0;
        end else begin
            hcount_nxt = hcount + 12'd1;
        end

        if (!h_wrap) begin
            vcount_nxt = vcount;
        end else if (vcount == v_total - 12'd1) begin
            vcount_nxt = 12'd0;
        end else begin
            vcount_nxt = vcount + 12'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= 12'd0;
            vcount <= 12'd0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
        end else begin
            hcount <= hcount_nxt;
            vcount <= vcount_nxt;
            // Sync window is start inclusive, end exclusive
            hsync  <= (hcount_nxt >= h_sync_start) && (hcount_nxt < h_sync_end);
            vsync  <= (vcount_nxt >= v_sync_start) && (vcount_nxt < v_sync_end);
            hblnk  <= (hcount_nxt >= h_active);
            vblnk  <= (vcount_nxt >= v_active);
        end
    end

endmodule

//--- game_display.f
design/game_pkg.sv
design/vga_timing.sv
design/game_mode_ctrl.sv
design/draw_background.sv
design/draw_marker.sv
design/game_display_top.sv
tests/tb_clock.sv
tests/game_display_sva.sv
tests/game_display_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the game display testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module game_display_tb -f game_display.f -o game_display_sim; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/game_display_sim)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "=== PASS ==="; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

//--- tests/game_display_sva.sv
module game_display_sva (
    input logic                 clk,
    input logic                 rst,
    input logic                 btn_left,
    input logic                 click,
    input logic                 play_hit,
    input logic                 win,
    input logic                 lose,
    input logic                 peer_ready,
    input logic [11:0]          vga_hcount,
    input logic [11:0]          vga_vcount,
    input logic                 vga_hsync,
    input logic                 vga_vsync,
    input logic                 vga_blnk,
    input logic [11:0]          vga_rgb,
    input game_pkg::game_mode_e mode
);

    timeunit 1ns;
    timeprecision 1ps;

    import game_pkg::*;

    // Everything sits at zero once reset has been sampled
    a_reset_zero: assert property (@(posedge clk)
        $past(rst) |-> (vga_hcount == 12'd0) && (vga_vcount == 12'd0) && !vga_hsync &&
                       !vga_vsync && !vga_blnk && (vga_rgb == 12'd0) && (mode == mode_menu))
        else $error("Top level outputs are not zero after reset");

    // The two reset-filled stages repeat pixel 0, so skip them
    a_hcount_step: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) && !$past(rst, 2) && !$past(rst, 3) |->
            vga_hcount == (($past(vga_hcount) == h_total - 12'd1) ? 12'd0
                                                                   : $past(vga_hcount) + 12'd1))
        else $error("vga_hcount did not advance by one or wrap");

    a_mode_cause: assert property (@(posedge clk) disable iff (rst)
        (mode != $past(mode)) |-> $past(btn_left || click || play_hit || win || lose || peer_ready))
        else $error("Mode changed without an event in the cycle before");

endmodule

bind game_display_top game_display_sva u_game_display_sva (
    .clk        (clk),
    .rst        (rst),
    .btn_left   (btn_left),
    .click      (click),
    .play_hit   (play_hit),
    .win        (win),
    .lose       (lose),
    .peer_ready (peer_ready),
    .vga_hcount (vga_hcount),
    .vga_vcount (vga_vcount),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync),
    .vga_blnk   (vga_blnk),
    .vga_rgb    (vga_rgb),
    .mode       (mode)
);

//--- tests/game_display_tb.sv
module game_display_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import game_pkg::*;

    localparam int frame_cycles   = int'(h_total) * int'(v_total);
    localparam int timeout_cycles = 4 * frame_cycles + 10000;

    // Event bits in the order btn_left, click, play_hit, win, lose
    localparam logic [4:0] ev_btn   = 5'b10000;
    localparam logic [4:0] ev_click = 5'b01000;
    localparam logic [4:0] ev_play  = 5'b00100;
    localparam logic [4:0] ev_win   = 5'b00010;
    localparam logic [4:0] ev_lose  = 5'b00001;

    // MENU title bars as x0, x1, y0, y1 with lower < x <= upper
    localparam int title_box [14][4] = '{
        '{170, 210, 90, 250}, '{170, 370, 50, 90}, '{250, 290, 90, 250},
        '{330, 370, 90, 250}, '{420, 460, 50, 250}, '{460, 500, 50, 90},
        '{460, 500, 130, 170}, '{460, 500, 210, 250}, '{550, 590, 90, 250},
        '{550, 670, 50, 90}, '{630, 670, 90, 250}, '{720, 760, 50, 210},
        '{720, 840, 210, 250}, '{800, 840, 50, 210}
    };

    logic        clk;
    logic        rst;
    logic        btn_left, click, play_hit, win, lose;
    logic        multi, peer_ready;
    logic [11:0] player_x, player_y;
    logic [11:0] vga_hcount, vga_vcount, vga_rgb;
    logic        vga_hsync, vga_vsync, vga_blnk;
    game_mode_e  mode;

    // Comparator state
    game_mode_e  model_mode, mode_d1, mode_d2;
    logic [11:0] px_q, py_q;
    int          run_cnt, exp_h, exp_v, cycle_cnt;

    tb_clock u_tb_clock (.clk(clk));

    game_display_top UUT (
        .clk(clk), .rst(rst), .btn_left(btn_left), .click(click), .play_hit(play_hit),
        .win(win), .lose(lose), .multi(multi), .peer_ready(peer_ready),
        .player_x(player_x), .player_y(player_y), .vga_hcount(vga_hcount),
        .vga_vcount(vga_vcount), .vga_hsync(vga_hsync), .vga_vsync(vga_vsync),
        .vga_blnk(vga_blnk), .vga_rgb(vga_rgb), .mode(mode)
    );

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    function automatic game_mode_e mode_next(input game_mode_e cur, input logic btn,
                                             input logic clk_ev, input logic play,
                                             input logic w, input logic l,
                                             input logic mul, input logic peer);
        if (btn && cur != mode_menu) return mode_menu;
        if (cur == mode_menu && play) return mul ? mode_wait : mode_game;
        if (cur == mode_wait && peer) return mode_game;
        if (cur == mode_game && w) return mode_victory;
        if (cur == mode_game && l) return mode_over;
        if ((cur == mode_victory || cur == mode_over) && clk_ev) return mode_menu;
        if (cur == mode_over && play) return mode_game;
        return cur;
    endfunction

    function automatic logic title_hit(input int h, input int v);
        for (int i = 0; i < 14; i++) begin
            if (h > title_box[i][0] && h <= title_box[i][1] &&
                v > title_box[i][2] && v <= title_box[i][3]) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic [11:0] pixel_ref(input int h, input int v, input game_mode_e m,
                                              input int px, input int py);
        int  cx;
        int  cy;
        logic outer;
        logic inner;
        cx = (px < left_h_line) ? left_h_line :
             (px > right_h_line - marker_size) ? right_h_line - marker_size : px;
        cy = (py < top_v_line) ? top_v_line :
             (py > bottom_v_line - marker_size) ? bottom_v_line - marker_size : py;
        outer = h >= left_h_line - border && h < right_h_line + border &&
                v >= top_v_line - border && v < bottom_v_line + border;
        inner = h >= left_h_line && h < right_h_line && v >= top_v_line && v < bottom_v_line;
        if (m == mode_victory) return col_victory;
        if (m == mode_over) return col_over;
        if (m == mode_wait) return col_wait;
        if (h >= h_active || v >= v_active) return col_black;
        if (m == mode_game && h >= cx && h < cx + marker_size &&
            v >= cy && v < cy + marker_size) return col_marker;
        if (v == 0) return col_yellow;
        if (v == v_active - 1) return col_red;
        if (h == 0) return col_green;
        if (h == h_active - 1) return col_blue;
        if (m == mode_menu) return title_hit(h, v) ? col_white : col_black;
        return (outer && !inner) ? col_white : col_black;
    endfunction

    task automatic apply_event(input logic [4:0] ev, input game_mode_e exp_mode);
        @(negedge clk);
        {btn_left, click, play_hit, win, lose} = ev;
        @(negedge clk);
        {btn_left, click, play_hit, win, lose} = 5'b00000;
        check_equal("mode", mode, exp_mode);
    endtask

    task automatic run_frame();
        repeat (frame_cycles) @(negedge clk);
    endtask

    // Checks the mode every cycle and the pixel two stages after the counters
    always @(posedge clk) begin
        if (rst) begin
            model_mode = mode_menu;
            mode_d1    = mode_menu;
            mode_d2    = mode_menu;
            run_cnt    = 0;
            exp_h      = 0;
            exp_v      = 0;
        end else begin
            check_equal("mode", mode, model_mode);
            model_mode = mode_next(model_mode, btn_left, click, play_hit, win, lose,
                                   multi, peer_ready);
            run_cnt++;
            if (run_cnt >= 3) begin
                check_equal("vga_hcount", vga_hcount, exp_h);
                check_equal("vga_vcount", vga_vcount, exp_v);
                check_equal("vga_hsync", vga_hsync, exp_h >= h_sync_start && exp_h < h_sync_end);
                check_equal("vga_vsync", vga_vsync, exp_v >= v_sync_start && exp_v < v_sync_end);
                check_equal("vga_blnk", vga_blnk, exp_h >= h_active || exp_v >= v_active);
                check_equal("vga_rgb", vga_rgb, pixel_ref(exp_h, exp_v, mode_d2, px_q, py_q));
                if (exp_h == h_total - 1) begin
                    exp_h = 0;
                    exp_v = (exp_v == v_total - 1) ? 0 : exp_v + 1;
                end else begin
                    exp_h++;
                end
            end
            mode_d2 = mode_d1;
            mode_d1 = mode;
            px_q    = player_x;
            py_q    = player_y;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("=== FAIL ===");
            $fatal(1, "Stopped by the cycle limit");
        end
    end

    initial begin
        cycle_cnt = 0;
        void'($urandom(51));
        rst = 1'b1;
        {btn_left, click, play_hit, win, lose} = 5'b00000;
        multi = 1'b0;
        peer_ready = 1'b0;
        player_x = 12'd0;
        player_y = 12'd0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        // Menu screen for a whole frame
        check_equal("mode", mode, mode_menu);
        run_frame();

        // Single player game with the marker at a random spot that may need clamping
        player_x = 12'(300 + $urandom % 420);
        player_y = 12'(260 + $urandom % 400);
        apply_event(ev_play, mode_game);
        run_frame();

        // Victory and game over screens, then a win beating a loss
        apply_event(ev_win, mode_victory);
        run_frame();
        apply_event(ev_click, mode_menu);
        apply_event(ev_play, mode_game);
        apply_event(ev_lose, mode_over);
        run_frame();
        apply_event(ev_play, mode_game);
        apply_event(ev_win | ev_lose, mode_victory);

        // Multiplayer wait until the peer is ready
        apply_event(ev_btn, mode_menu);
        multi = 1'b1;
        apply_event(ev_play, mode_wait);
        repeat (20) @(negedge clk);
        check_equal("mode", mode, mode_wait);
        peer_ready = 1'b1;
        @(negedge clk);
        peer_ready = 1'b0;
        multi = 1'b0;
        check_equal("mode", mode, mode_game);

        // Ways back to the menu
        apply_event(ev_btn, mode_menu);
        multi = 1'b1;
        apply_event(ev_play, mode_wait);
        apply_event(ev_btn, mode_menu);
        multi = 1'b0;
        apply_event(ev_play, mode_game);
        apply_event(ev_lose, mode_over);
        apply_event(ev_btn, mode_menu);
        apply_event(ev_play, mode_game);
        apply_event(ev_win, mode_victory);
        apply_event(ev_btn, mode_menu);
        apply_event(ev_play, mode_game);
        apply_event(ev_lose, mode_over);
        apply_event(ev_click, mode_menu);

        // Random events that the comparator follows with mode_next
        for (int i = 0; i < 200; i++) begin
            @(negedge clk);
            multi = 1'($urandom % 2);
            peer_ready = ($urandom % 4) == 0;
            {btn_left, click, play_hit, win, lose} = 5'b00001 << ($urandom % 5);
            @(negedge clk);
            {btn_left, click, play_hit, win, lose} = 5'b00000;
            peer_ready = 1'b0;
        end

        repeat (5) @(negedge clk);
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- tests/tb_clock.sv
module tb_clock (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    localparam time half_period = 10ns;

    initial begin
        clk = 1'b0;
        forever begin
            #half_period clk = ~clk;
        end
    end

endmodule
